// ==== source/cmd_pkg.sv ====
/*
 Shared definitions for the rasterizer command front end.
 Opcode in bits 31..28, immediate in bits 13..0. Every stream carries whole
 32-bit words. Unknown opcodes are treated as nop by the decoder.
*/
`default_nettype none

package cmd_pkg;

    localparam int cmd_width = 32;

    typedef enum logic [3:0] {
        op_nop           = 4'd0,
        op_triangle      = 4'd1,
        op_texture       = 4'd2,
        op_fog_lut       = 4'd3,
        op_render_config = 4'd4,
        op_framebuffer   = 4'd5
    } opcode_t;

    localparam int op_pos   = 28;
    localparam int op_size  = 4;
    localparam int imm_pos  = 0;
    localparam int imm_size = 14;

    typedef logic [imm_size-1:0] imm_t;

    // Framebuffer command bits
    localparam int fb_commit_pos    = 0;
    localparam int fb_memset_pos    = 1;
    localparam int fb_color_sel_pos = 2;
    localparam int fb_depth_sel_pos = 3;

    typedef struct packed {
        logic [cmd_width-1:0] data;
        logic                 last;
    } stream_beat_t;

    // Register index noted per field
    typedef struct packed {
        logic [15:0] reg1;           // 0
        logic [15:0] reg2;           // 1
        logic [15:0] tex_env_color;  // 2
        logic [15:0] fog_color;      // 3
        logic [15:0] color_clear;    // 4
        logic [15:0] depth_clear;    // 5
    } render_config_t;

    typedef struct packed {
        logic commit;
        logic memset;
    } fb_cmd_t;

    // Output stream indices
    localparam int num_streams = 3;

    typedef logic [1:0] stream_sel_t;

    localparam stream_sel_t stream_triangle = 2'd0;
    localparam stream_sel_t stream_texture  = 2'd1;
    localparam stream_sel_t stream_fog      = 2'd2;

endpackage

`default_nettype wire

// ==== source/stream_port.sv ====
/*
 One-entry registered stream slice.
 in_ready is high when empty or when the held beat leaves this cycle.
 done pulses for one cycle as a beat with last set is taken downstream.
*/
`timescale 1ns/100ps
`default_nettype none

module stream_port (
    input  logic                  aclk,
    input  logic                  resetn,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  cmd_pkg::stream_beat_t in_beat,
    output logic                  out_valid,
    input  logic                  out_ready,
    output cmd_pkg::stream_beat_t out_beat,
    output logic                  busy,
    output logic                  done
);

    logic full;

    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign busy      = full;
    assign done      = full && out_ready && out_beat.last;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            full <= 1'b0;
        end
        else if (in_valid && in_ready)
        begin
            full <= 1'b1;
        end
        else if (out_ready)
        begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (in_valid && in_ready)
            out_beat <= in_beat;
    end

    // Held beat must not change under back-pressure
    assert property (@(posedge aclk) disable iff (!resetn)
        (out_valid && !out_ready) |=> $stable(out_beat));

endmodule

`default_nettype wire

// ==== source/cmd_decoder.sv ====
/*
 Command decoder. Waits for idle before each command.
 Burst words go straight to the selected port; cmd_ready follows its in_ready.
 Zero-length bursts and unknown opcodes return to the wait state.
 Config indices 6 and 7 are ignored.
*/
`timescale 1ns/100ps
`default_nettype none

module cmd_decoder #(
    parameter int FOG_LUT_WORDS = 33
) (
    input  logic                                          aclk,
    input  logic                                          resetn,
    input  logic                                          cmd_valid,
    output logic                                          cmd_ready,
    input  logic [31:0]                                   cmd_data,
    output logic [cmd_pkg::num_streams-1:0]               port_in_valid,
    input  logic [cmd_pkg::num_streams-1:0]               port_in_ready,
    output cmd_pkg::stream_beat_t [cmd_pkg::num_streams-1:0] port_in_beat,
    output logic [cmd_pkg::num_streams-1:0]               burst_start,
    output logic                                          fb_request,
    output logic                                          fb_color_sel,
    output logic                                          fb_depth_sel,
    output cmd_pkg::fb_cmd_t                              fb_cmd,
    output cmd_pkg::render_config_t                       render_config,
    input  logic                                          idle
);

    localparam cmd_pkg::imm_t fog_len = cmd_pkg::imm_t'(FOG_LUT_WORDS);

    typedef enum logic [1:0] {
        st_wait_idle,
        st_command,
        st_burst,
        st_config_value
    } state_t;

    state_t               state;
    cmd_pkg::imm_t        burst_count;
    cmd_pkg::stream_sel_t stream_sel;
    logic [2:0]           cfg_index;

    cmd_pkg::opcode_t     opcode;
    cmd_pkg::imm_t        burst_len;
    cmd_pkg::stream_sel_t burst_sel;
    logic                 is_burst;

    assign opcode = cmd_pkg::opcode_t'(cmd_data[cmd_pkg::op_pos +: cmd_pkg::op_size]);

    // Burst length and target for the word on the input
    always_comb
    begin
        burst_len = cmd_data[cmd_pkg::imm_pos +: cmd_pkg::imm_size];
        burst_sel = cmd_pkg::stream_triangle;
        is_burst  = 1'b1;
        case (opcode)
            cmd_pkg::op_triangle:
                burst_sel = cmd_pkg::stream_triangle;
            cmd_pkg::op_texture:
                burst_sel = cmd_pkg::stream_texture;
            cmd_pkg::op_fog_lut:
            begin
                burst_sel = cmd_pkg::stream_fog;
                burst_len = fog_len;
            end
            default:
                is_burst = 1'b0;
        endcase
    end

    always_comb
    begin
        case (state)
            st_command:      cmd_ready = 1'b1;
            st_config_value: cmd_ready = 1'b1;
            st_burst:        cmd_ready = port_in_ready[stream_sel];
            default:         cmd_ready = 1'b0;
        endcase
    end

    always_comb
    begin
        burst_start   = '0;
        port_in_valid = '0;
        if (state == st_command && cmd_valid && is_burst && burst_len != '0)
            burst_start[burst_sel] = 1'b1;
        if (state == st_burst)
            port_in_valid[stream_sel] = cmd_valid;
        for (int i = 0; i < cmd_pkg::num_streams; i++)
        begin
            port_in_beat[i].data = cmd_data;
            port_in_beat[i].last = (burst_count == cmd_pkg::imm_t'(1));
        end
    end

    // Buffer request is taken straight off the accepted command
    assign fb_request   = (state == st_command) && cmd_valid &&
                          (opcode == cmd_pkg::op_framebuffer);
    assign fb_color_sel = cmd_data[cmd_pkg::fb_color_sel_pos];
    assign fb_depth_sel = cmd_data[cmd_pkg::fb_depth_sel_pos];

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state         <= st_wait_idle;
            render_config <= '0;
        end
        else
        begin
            case (state)
                st_wait_idle:
                    if (idle)
                        state <= st_command;
                st_command:
                    if (cmd_valid)
                    begin
                        burst_count <= burst_len;
                        stream_sel  <= burst_sel;
                        cfg_index   <= cmd_data[cmd_pkg::imm_pos +: 3];
                        if (is_burst && burst_len != '0)
                            state <= st_burst;
                        else if (opcode == cmd_pkg::op_render_config)
                            state <= st_config_value;
                        else
                            state <= st_wait_idle;
                        if (opcode == cmd_pkg::op_framebuffer)
                        begin
                            fb_cmd.commit <= cmd_data[cmd_pkg::fb_commit_pos];
                            fb_cmd.memset <= cmd_data[cmd_pkg::fb_memset_pos];
                        end
                    end
                st_burst:
                    if (cmd_valid && cmd_ready)
                    begin
                        burst_count <= burst_count - 1'b1;
                        if (burst_count == cmd_pkg::imm_t'(1))
                            state <= st_wait_idle;
                    end
                st_config_value:
                    if (cmd_valid)
                    begin
                        case (cfg_index)
                            3'd0: render_config.reg1          <= cmd_data[15:0];
                            3'd1: render_config.reg2          <= cmd_data[15:0];
                            3'd2: render_config.tex_env_color <= cmd_data[15:0];
                            3'd3: render_config.fog_color     <= cmd_data[15:0];
                            3'd4: render_config.color_clear   <= cmd_data[15:0];
                            3'd5: render_config.depth_clear   <= cmd_data[15:0];
                            default: ;
                        endcase
                        state <= st_wait_idle;
                    end
                default:
                    state <= st_wait_idle;
            endcase
        end
    end

    // Only one output stream is fed at a time
    assert property (@(posedge aclk) disable iff (!resetn) $onehot0(port_in_valid));

    assert property (@(posedge aclk) disable iff (!resetn)
        (state == st_wait_idle) |-> !cmd_ready);

endmodule

`default_nettype wire

// ==== source/render_sequencer.sv ====
/*
 Tracks outstanding bursts, the start-rendering handshake and buffer applies.
 idle is a level that lets the decoder take the next command.
 A framebuffer command with neither buffer selected starts no apply.
*/
`timescale 1ns/100ps
`default_nettype none

module render_sequencer (
    input  logic                            aclk,
    input  logic                            resetn,
    input  logic [cmd_pkg::num_streams-1:0] burst_start,
    input  logic [cmd_pkg::num_streams-1:0] port_busy,
    input  logic [cmd_pkg::num_streams-1:0] port_done,
    input  logic                            fb_request,
    input  logic                            fb_color_sel,
    input  logic                            fb_depth_sel,
    output logic                            idle,
    output logic                            start_rendering,
    input  logic                            rasterizer_running,
    input  logic                            pixel_in_pipeline,
    output logic                            color_apply,
    input  logic                            color_applied,
    output logic                            depth_apply,
    input  logic                            depth_applied
);

    typedef enum logic {
        fb_wait_request,
        fb_wait_end
    } fb_state_t;

    fb_state_t                       fb_state;
    logic                            apply_pending;
    logic [cmd_pkg::num_streams-1:0] outstanding;
    logic                            both_applied;

    assign both_applied = color_applied && depth_applied;

    assign idle = !(|outstanding) && !(|port_busy) && !apply_pending &&
                  !start_rendering && !rasterizer_running && !pixel_in_pipeline;

    // Burst flags and rasterizer kick
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            outstanding     <= '0;
            start_rendering <= 1'b0;
        end
        else
        begin
            outstanding <= (outstanding | burst_start) & ~port_done;
            if (port_done[cmd_pkg::stream_triangle])
                start_rendering <= 1'b1;
            else if (rasterizer_running)
                start_rendering <= 1'b0;
        end
    end

    // Buffer apply tracker
    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            fb_state      <= fb_wait_request;
            apply_pending <= 1'b0;
            color_apply   <= 1'b0;
            depth_apply   <= 1'b0;
        end
        else
        begin
            if (fb_request && (fb_color_sel || fb_depth_sel))
            begin
                apply_pending <= 1'b1;
                color_apply   <= fb_color_sel;
                depth_apply   <= fb_depth_sel;
            end
            else
            begin
                // Drop each request once its unit has picked it up
                if (!color_applied)
                    color_apply <= 1'b0;
                if (!depth_applied)
                    depth_apply <= 1'b0;
            end
            case (fb_state)
                fb_wait_request:
                    if (apply_pending && !both_applied)
                        fb_state <= fb_wait_end;
                fb_wait_end:
                    if (both_applied)
                    begin
                        fb_state      <= fb_wait_request;
                        apply_pending <= 1'b0;
                    end
                default:
                    fb_state <= fb_wait_request;
            endcase
        end
    end

    // Decoder must hold off framebuffer commands until the last apply ends
    assert property (@(posedge aclk) disable iff (!resetn) fb_request |-> !apply_pending);

endmodule

`default_nettype wire

// ==== source/cmd_frontend.sv ====
/*
 Command front end top level.
 One decoder feeds three identical stream ports (triangle, texture, fog).
 A burst reaches its output two cycles after the command is accepted.
 FOG_LUT_WORDS sets the fog table burst length.
*/
`timescale 1ns/100ps
`default_nettype none

module cmd_frontend #(
    parameter int FOG_LUT_WORDS = 33
) (
    input  logic                    aclk,
    input  logic                    resetn,
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  logic [31:0]             cmd_data,
    output logic                    tri_valid,
    input  logic                    tri_ready,
    output cmd_pkg::stream_beat_t   tri_beat,
    output logic                    tex_valid,
    input  logic                    tex_ready,
    output cmd_pkg::stream_beat_t   tex_beat,
    output logic                    fog_valid,
    input  logic                    fog_ready,
    output cmd_pkg::stream_beat_t   fog_beat,
    input  logic                    rasterizer_running,
    output logic                    start_rendering,
    input  logic                    pixel_in_pipeline,
    output logic                    color_apply,
    input  logic                    color_applied,
    output logic                    depth_apply,
    input  logic                    depth_applied,
    output cmd_pkg::fb_cmd_t        fb_cmd,
    output cmd_pkg::render_config_t render_config
);

    localparam int n = cmd_pkg::num_streams;

    logic [n-1:0]                  port_in_valid;
    logic [n-1:0]                  port_in_ready;
    cmd_pkg::stream_beat_t [n-1:0] port_in_beat;
    logic [n-1:0]                  port_out_valid;
    logic [n-1:0]                  port_out_ready;
    cmd_pkg::stream_beat_t [n-1:0] port_out_beat;
    logic [n-1:0]                  port_busy;
    logic [n-1:0]                  port_done;
    logic [n-1:0]                  burst_start;
    logic                          fb_request;
    logic                          fb_color_sel;
    logic                          fb_depth_sel;
    logic                          idle;

    cmd_decoder #(
        .FOG_LUT_WORDS(FOG_LUT_WORDS)
    ) i_cmd_decoder (
        .aclk          (aclk),
        .resetn        (resetn),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .cmd_data      (cmd_data),
        .port_in_valid (port_in_valid),
        .port_in_ready (port_in_ready),
        .port_in_beat  (port_in_beat),
        .burst_start   (burst_start),
        .fb_request    (fb_request),
        .fb_color_sel  (fb_color_sel),
        .fb_depth_sel  (fb_depth_sel),
        .fb_cmd        (fb_cmd),
        .render_config (render_config),
        .idle          (idle)
    );

    assign port_out_ready[cmd_pkg::stream_triangle] = tri_ready;
    assign port_out_ready[cmd_pkg::stream_texture]  = tex_ready;
    assign port_out_ready[cmd_pkg::stream_fog]      = fog_ready;

    for (genvar i = 0; i < n; i++)
    begin : g_port
        stream_port i_stream_port (
            .aclk      (aclk),
            .resetn    (resetn),
            .in_valid  (port_in_valid[i]),
            .in_ready  (port_in_ready[i]),
            .in_beat   (port_in_beat[i]),
            .out_valid (port_out_valid[i]),
            .out_ready (port_out_ready[i]),
            .out_beat  (port_out_beat[i]),
            .busy      (port_busy[i]),
            .done      (port_done[i])
        );
    end

    assign tri_valid = port_out_valid[cmd_pkg::stream_triangle];
    assign tri_beat  = port_out_beat[cmd_pkg::stream_triangle];
    assign tex_valid = port_out_valid[cmd_pkg::stream_texture];
    assign tex_beat  = port_out_beat[cmd_pkg::stream_texture];
    assign fog_valid = port_out_valid[cmd_pkg::stream_fog];
    assign fog_beat  = port_out_beat[cmd_pkg::stream_fog];

    render_sequencer i_render_sequencer (
        .aclk               (aclk),
        .resetn             (resetn),
        .burst_start        (burst_start),
        .port_busy          (port_busy),
        .port_done          (port_done),
        .fb_request         (fb_request),
        .fb_color_sel       (fb_color_sel),
        .fb_depth_sel       (fb_depth_sel),
        .idle               (idle),
        .start_rendering    (start_rendering),
        .rasterizer_running (rasterizer_running),
        .pixel_in_pipeline  (pixel_in_pipeline),
        .color_apply        (color_apply),
        .color_applied      (color_applied),
        .depth_apply        (depth_apply),
        .depth_applied      (depth_applied)
    );

endmodule

`default_nettype wire

// ==== tests/tb_cmd_frontend.sv ====
/*
 Directed testbench for the command front end.
 Rasterizer and buffer units are simple timed models.
 Expected output words are queued per stream and checked in order.
*/
`timescale 1ns/100ps
`default_nettype none

module tb_cmd_frontend;

    localparam int fog_words      = 33;
    localparam int timeout_cycles = 4000;

    logic aclk = 1'b0;
    logic resetn, cmd_valid, cmd_ready;
    logic [31:0] cmd_data;
    logic tri_valid, tri_ready, tex_valid, tex_ready, fog_valid, fog_ready;
    cmd_pkg::stream_beat_t tri_beat, tex_beat, fog_beat;
    logic rasterizer_running, start_rendering, pixel_in_pipeline;
    logic color_apply, color_applied, depth_apply, depth_applied;
    cmd_pkg::fb_cmd_t        fb_cmd;
    cmd_pkg::render_config_t render_config;
    cmd_pkg::render_config_t exp_cfg = '0;

    cmd_pkg::stream_beat_t exp_q [3][$];
    logic [2:0]            out_valid, out_ready;
    cmd_pkg::stream_beat_t [2:0] out_beat;

    int    seed = 32'h9b9b;
    int    errors = 0, tests_run = 0, err_start = 0, cycles = 0;
    int    rast_cnt = 0, rast_starts = 0;
    int    buf_cnt [2] = '{0, 0};
    logic  rand_ready = 1'b0;
    logic  color_restored = 1'b0;
    logic  restored_at_accept = 1'b0;
    string cur_test = "reset";

    cmd_frontend #(
        .FOG_LUT_WORDS(fog_words)
    ) i_cmd_frontend (
        .aclk (aclk), .resetn (resetn),
        .cmd_valid (cmd_valid), .cmd_ready (cmd_ready), .cmd_data (cmd_data),
        .tri_valid (tri_valid), .tri_ready (tri_ready), .tri_beat (tri_beat),
        .tex_valid (tex_valid), .tex_ready (tex_ready), .tex_beat (tex_beat),
        .fog_valid (fog_valid), .fog_ready (fog_ready), .fog_beat (fog_beat),
        .rasterizer_running (rasterizer_running), .start_rendering (start_rendering),
        .pixel_in_pipeline (pixel_in_pipeline),
        .color_apply (color_apply), .color_applied (color_applied),
        .depth_apply (depth_apply), .depth_applied (depth_applied),
        .fb_cmd (fb_cmd), .render_config (render_config)
    );

    always #5 aclk = ~aclk;

    assign out_valid = {fog_valid, tex_valid, tri_valid};
    assign out_ready = {fog_ready, tex_ready, tri_ready};
    assign out_beat  = {fog_beat, tex_beat, tri_beat};

    // Rasterizer runs for five cycles, buffers drop applied for three
    assign rasterizer_running = (rast_cnt >= 2) && (rast_cnt < 7);
    assign color_applied      = !(buf_cnt[0] >= 2 && buf_cnt[0] <= 4);
    assign depth_applied      = !(buf_cnt[1] >= 2 && buf_cnt[1] <= 4);

    always @(negedge aclk)
    begin : models
        logic [31:0] r;
        logic [1:0]  apply;
        r     = $random(seed);
        apply = {depth_apply, color_apply};
        tri_ready = rand_ready ? r[0] : 1'b1;
        tex_ready = rand_ready ? r[1] : 1'b1;
        fog_ready = rand_ready ? r[2] : 1'b1;
        if (rast_cnt != 0)
            rast_cnt = (rast_cnt == 7) ? 0 : rast_cnt + 1;
        else if (resetn && start_rendering)
        begin
            rast_cnt = 1;
            rast_starts++;
        end
        for (int b = 0; b < 2; b++)
        begin
            if (buf_cnt[b] != 0)
                buf_cnt[b] = (buf_cnt[b] == 5) ? 0 : buf_cnt[b] + 1;
            else if (resetn && apply[b])
                buf_cnt[b] = 1;
        end
        if (buf_cnt[0] == 5)
            color_restored = 1'b1;
    end

    always @(posedge aclk)
    begin
        cycles++;
        if (cycles >= timeout_cycles)
        begin
            $display("Timeout: run stopped after %0d cycles in test %s", cycles, cur_test);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_val(input string what, input logic [95:0] exp_v,
                             input logic [95:0] act_v);
        assert (exp_v === act_v)
        else
        begin
            $display("ERROR %s %s: expected %0h, actual %0h", cur_test, what, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond)
        else
        begin
            $display("Test %s failed: %s", cur_test, msg);
            errors++;
        end
    endtask

    // Compare every output transfer against the head of its queue
    always @(posedge aclk)
    begin : monitor
        cmd_pkg::stream_beat_t exp_beat;
        for (int s = 0; s < 3; s++)
        begin
            if (resetn && out_valid[s] && out_ready[s])
            begin
                check_true(exp_q[s].size() != 0, $sformatf("unexpected beat on stream %0d", s));
                if (exp_q[s].size() != 0)
                begin
                    exp_beat = exp_q[s].pop_front();
                    check_val($sformatf("stream %0d beat", s), exp_beat, out_beat[s]);
                end
            end
        end
    end

    function automatic logic [31:0] make_cmd(input logic [3:0] op, input logic [13:0] imm);
        return {op, 14'd0, imm};
    endfunction

    // Called on a falling edge and returns on the falling edge after acceptance
    task automatic send_word(input logic [31:0] word);
        cmd_valid = 1'b1;
        cmd_data  = word;
        @(posedge aclk);
        while (!cmd_ready)
            @(posedge aclk);
        restored_at_accept = color_restored;
        @(negedge aclk);
        cmd_valid = 1'b0;
    endtask

    task automatic send_burst(input logic [3:0] op, input int s, input int n,
                              input logic [13:0] imm);
        cmd_pkg::stream_beat_t beat;
        send_word(make_cmd(op, imm));
        for (int i = 0; i < n; i++)
        begin
            beat.data = $random(seed);
            beat.last = (i == n - 1);
            exp_q[s].push_back(beat);
            send_word(beat.data);
        end
    endtask

    // Decoder back in the command state means the whole system is idle
    task automatic wait_drained();
        @(posedge aclk);
        while (!cmd_ready || (exp_q[0].size() + exp_q[1].size() + exp_q[2].size()) != 0)
            @(posedge aclk);
        @(negedge aclk);
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        err_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        $display("Test %-12s %s", cur_test, (errors == err_start) ? "ok" : "FAILED");
    endtask

    task automatic test_reset();
        begin_test("reset");
        check_val("cmd_ready", 1'b0, cmd_ready);
        check_val("output valids", 3'b000, {tri_valid, tex_valid, fog_valid});
        check_val("start/apply", 3'b000, {start_rendering, color_apply, depth_apply});
        check_val("config", '0, render_config);
        end_test();
    endtask

    task automatic test_triangle();
        begin_test("triangle");
        rand_ready = 1'b1;
        send_burst(4'd1, cmd_pkg::stream_triangle, 12, 14'd12);
        @(posedge aclk);
        while (!start_rendering)
            @(posedge aclk);
        while (!rasterizer_running)
            @(posedge aclk);
        @(negedge aclk);
        check_val("start_rendering after running", 1'b0, start_rendering);
        while (rasterizer_running)
        begin
            check_true(!cmd_ready, "cmd_ready rose while the rasterizer was running");
            @(posedge aclk);
        end
        wait_drained();
        end_test();
    endtask

    task automatic test_texture_fog();
        int starts;
        begin_test("texture_fog");
        starts = rast_starts;
        send_burst(4'd2, cmd_pkg::stream_texture, 20, 14'd20);
        wait_drained();
        send_burst(4'd3, cmd_pkg::stream_fog, fog_words, 14'd0);
        wait_drained();
        check_true(rast_starts == starts,
                   "rendering started by a texture or fog burst");
        rand_ready = 1'b0;
        end_test();
    endtask

    task automatic test_config();
        begin_test("config");
        send_word(make_cmd(4'd4, 14'd3));
        send_word(32'h1234_a5c3);
        exp_cfg.fog_color = 16'ha5c3;
        send_word(make_cmd(4'd4, 14'd5));
        send_word(32'h0bad_7e11);
        exp_cfg.depth_clear = 16'h7e11;
        check_val("config after index 3 and 5", exp_cfg, render_config);
        send_word(make_cmd(4'd4, 14'd7));
        send_word(32'hffff_ffff);
        check_val("config after index 7", exp_cfg, render_config);
        end_test();
    endtask

    task automatic test_framebuffer();
        begin_test("framebuffer");
        color_restored = 1'b0;
        // Commit with color select only
        send_word(make_cmd(4'd5, 14'd5));
        check_val("color_apply", 1'b1, color_apply);
        check_val("depth_apply", 1'b0, depth_apply);
        check_val("fb_cmd", 2'b10, fb_cmd);
        send_word(make_cmd(4'd0, 14'd0));
        check_true(restored_at_accept, "next command accepted before color_applied returned");
        wait_drained();
        check_val("apply after request", 2'b00, {color_apply, depth_apply});
        end_test();
    endtask

    task automatic test_nop_zero();
        int starts;
        begin_test("nop_zero");
        starts = rast_starts;
        send_word(make_cmd(4'd0, 14'd0));
        send_word(make_cmd(4'd1, 14'd0));
        send_word(make_cmd(4'hf, 14'd9));
        send_word(make_cmd(4'd4, 14'd0));
        send_word(32'h0000_5aa5);
        exp_cfg.reg1 = 16'h5aa5;
        check_val("config after nops", exp_cfg, render_config);
        wait_drained();
        check_true(rast_starts == starts && !start_rendering,
                   "start_rendering raised without a triangle burst");
        end_test();
    endtask

    initial
    begin
        resetn            = 1'b0;
        cmd_valid         = 1'b0;
        cmd_data          = '0;
        tri_ready         = 1'b1;
        tex_ready         = 1'b1;
        fog_ready         = 1'b1;
        pixel_in_pipeline = 1'b0;
        repeat (8) @(posedge aclk);
        @(negedge aclk);
        resetn = 1'b1;
        test_reset();
        test_triangle();
        test_texture_fog();
        test_config();
        test_framebuffer();
        test_nop_zero();
        $display("Summary: %0d tests run, %0d errors", tests_run, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rasterizer_cmd.f ====
source/cmd_pkg.sv
source/stream_port.sv
source/cmd_decoder.sv
source/render_sequencer.sv
source/cmd_frontend.sv
tests/tb_cmd_frontend.sv

// ==== Bender.yml ====
package:
  name: rasterizer_cmd

sources:
  - source/cmd_pkg.sv
  - source/stream_port.sv
  - source/cmd_decoder.sv
  - source/render_sequencer.sv
  - source/cmd_frontend.sv
  - target: test
    files:
      - tests/tb_cmd_frontend.sv
